// File: Bender.yml
package:
  name: frontend

sources:
  - hdl/isa_pkg.sv
  - hdl/mem_bus_pkg.sv
  - hdl/fetch_unit.sv
  - hdl/icache.sv
  - hdl/decode_unit.sv
  - hdl/execute_unit.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - dv/frontend_asserts.sv
      - dv/frontend_tb.sv

// File: all.f
hdl/isa_pkg.sv
hdl/mem_bus_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/frontend_top.sv
dv/frontend_asserts.sv
dv/frontend_tb.sv

// File: dv/frontend_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_asserts (
	input logic                 clock,
	input logic                 rst_n,
	input logic                 ar_valid,
	input mem_bus_pkg::rd_req_t ar,
	input logic                 ar_ready,
	input logic                 if_valid,
	input logic                 id_valid,
	input logic                 redirect,
	input logic                 retire_valid
);
	int unsigned violations = 0;

	// A pending read address holds until the memory accepts it.
	assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
	else begin
		$error("ar changed or dropped before ar_ready");
		violations++;
	end

	// A fetched word either stays offered or has moved into the decode register.
	assert property (@(posedge clock) disable iff (!rst_n)
		if_valid && !redirect |=> if_valid || id_valid)
	else begin
		$error("if_valid dropped without a handoff or redirect");
		violations++;
	end

	assert property (@(posedge clock) !rst_n |=> !retire_valid)
	else begin
		$error("retire_valid high in the cycle after reset");
		violations++;
	end

endmodule

bind frontend_top frontend_asserts u_asserts (.*);

`default_nettype wire

// File: dv/frontend_cases.txt
# T <name> | M <addr hex> <data hex> | E <pc hex> <rd dec> <wen 0/1> <wdata hex>
# Each test gives its memory image, then its expected retire trace in order.
T straight_line
M 00000000 00500093
M 00000004 12345137
M 00000008 fff10113
M 0000000c 7ff08193
M 00000010 fffff237
M 00000014 12320293
M 00000018 0000006f
E 00000000 1 1 00000005
E 00000004 2 1 12345000
E 00000008 2 1 12344fff
E 0000000c 3 1 00000804
E 00000010 4 1 fffff000
E 00000014 5 1 fffff123
E 00000018 0 1 0000001c
T cached_loop
M 00000000 0000106f
M 00001000 00000093
M 00001004 00300113
M 00001008 00108093
M 0000100c fe209ee3
M 00001010 00a08193
M 00001014 0000006f
E 00000000 0 1 00000004
E 00001000 1 1 00000000
E 00001004 2 1 00000003
E 00001008 1 1 00000001
E 0000100c 0 0 00000000
E 00001008 1 1 00000002
E 0000100c 0 0 00000000
E 00001008 1 1 00000003
E 0000100c 0 0 00000000
E 00001010 3 1 0000000d
E 00001014 0 1 00001018
T branch_jump
M 00000000 00700093
M 00000004 00700113
M 00000008 05500193
M 0000000c 00208663
M 00000010 00100193
M 00000014 00200193
M 00000018 010002ef
M 0000001c 00900193
M 00000020 00a00193
M 00000028 00128313
M 0000002c 00018393
M 00000030 0000006f
E 00000000 1 1 00000007
E 00000004 2 1 00000007
E 00000008 3 1 00000055
E 0000000c 0 0 00000000
E 00000018 5 1 0000001c
E 00000028 6 1 0000001d
E 0000002c 7 1 00000055
E 00000030 0 1 00000034
T cross_region
M 00000000 01100093
M 00000004 7fd0016f
M 00001000 02208193
M 00001004 00010213
M 00001008 838ff06f
M 00000040 00118293
M 00000044 7c10006f
E 00000000 1 1 00000011
E 00000004 2 1 00000008
E 00001000 3 1 00000033
E 00001004 4 1 00000008
E 00001008 0 1 0000100c
E 00000040 5 1 00000034
E 00000044 0 1 00000048
E 00001004 4 1 00000008
E 00001008 0 1 0000100c
E 00000040 5 1 00000034
T x0_and_illegal
M 00000000 12300013
M 00000004 00500093
M 00000008 01000113
M 0000000c ffffffff
M 00000010 abcde037
M 00000014 00100193
M 00000018 00109093
M 0000001c 00008213
M 00000020 0000006f
E 00000000 0 1 00000123
E 00000004 1 1 00000005
E 00000008 2 1 00000010
E 0000000c 0 0 00000000
E 00000010 0 1 abcde000
E 00000014 3 1 00000001
E 00000018 0 0 00000000
E 0000001c 4 1 00000005
E 00000020 0 1 00000024

// File: dv/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;
	import isa_pkg::*;
	import mem_bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int MEM_WORDS      = 2048;

	logic    clock;
	logic    rst_n;
	logic    ar_valid;
	rd_req_t ar;
	logic    ar_ready;
	logic    r_valid;
	rd_rsp_t r;
	logic    retire_valid;
	retire_t retire;

	// Backing store for 0x0000 to 0x1fff; other addresses read the background pattern.
	logic [31:0] mem [MEM_WORDS];
	retire_t     expected [$];
	string       test_name;
	int          tests_run;
	int          tests_failed;
	int          test_errors;
	int          errors;

	frontend_top #(
		.RESET_PC     (32'h0000_0000),
		.CACHED_BASE  (32'h0000_1000),
		.CACHED_LIMIT (32'h0000_2000),
		.CACHE_LINES  (16)
	) uut (.*);

	initial begin
		clock = 1'b0;
		forever begin
			#4 clock = ~clock;
		end
	end

	// Unloaded words decode as illegal opcodes and differ at every word address.
	function automatic logic [31:0] background_word(input logic [31:0] addr);
		return {addr[31:7] ^ addr[26:2], 7'h00};
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] addr);
		if (addr < 32'(MEM_WORDS * 4)) begin
			return mem[addr[12:2]];
		end
		return background_word(addr);
	endfunction

	// Memory model for the read bus. Each address and each beat waits 0 to 3 cycles.
	initial begin
		int          phase;
		int          delay;
		logic [31:0] beat_addr;
		logic [3:0]  beats_left;
		logic        incr;
		void'($urandom(32'h0e6a251d));
		phase      = 0;
		delay      = 0;
		beat_addr  = '0;
		beats_left = '0;
		incr       = 1'b0;
		ar_ready   = 1'b0;
		r_valid    = 1'b0;
		r          = '0;
		forever begin
			@(negedge clock);
			ar_ready = 1'b0;
			r_valid  = 1'b0;
			if (!rst_n) begin
				phase = 0;
			end else begin
				if (phase == 0 && ar_valid) begin
					delay = $urandom % 4;
					phase = 1;
				end
				if (phase == 1) begin
					if (delay == 0) begin
						ar_ready   = 1'b1;
						beat_addr  = ar.addr;
						beats_left = ar.len;
						incr       = (ar.burst == BURST_INCR);
						delay      = $urandom % 4;
						phase      = 2;
					end else begin
						delay--;
					end
				end else if (phase == 2) begin
					if (delay == 0) begin
						r_valid = 1'b1;
						r = '{data: read_word(beat_addr), resp: 2'b00, last: (beats_left == 0)};
						if (beats_left == 0) begin
							phase = 0;
						end else begin
							beats_left--;
							delay = $urandom % 4;
							if (incr) begin
								beat_addr = beat_addr + 32'd4;
							end
						end
					end else begin
						delay--;
					end
				end
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		expected.delete();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = background_word(32'(i) << 2);
		end
	endtask

	task automatic apply_reset();
		@(negedge clock);
		rst_n = 1'b0;
		repeat (3) @(negedge clock);
		rst_n = 1'b1;
	endtask

	task automatic check_field(input string field, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want) else begin
			$display("[FAIL] %0t ns retire.%s got %h expected %h", $time, field, got, want);
			test_errors++;
		end
	endtask

	task automatic wait_retire(output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			seen = retire_valid;
			cycles++;
		end
	endtask

	task automatic run_test();
		bit      seen;
		retire_t got;
		int      checked;
		test_errors = 0;
		checked     = 0;
		apply_reset();
		for (int i = 0; i < expected.size(); i++) begin
			wait_retire(seen);
			if (!seen) begin
				$display("Test %s: nothing retired within %0d cycles, still waiting for pc %h",
					test_name, TIMEOUT_CYCLES, expected[i].pc);
				test_errors++;
				break;
			end
			got = retire;
			check_field("pc", got.pc, expected[i].pc);
			check_field("rd", 32'(got.rd), 32'(expected[i].rd));
			check_field("wen", 32'(got.wen), 32'(expected[i].wen));
			check_field("wdata", got.wdata, expected[i].wdata);
			checked++;
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: ok, %0d retires checked", test_name, checked);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, test_errors);
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          rd;
		int          wen;
		int          asserts_failed;
		string       line;
		string       name;
		logic [31:0] a;
		logic [31:0] d;
		bit          pending;
		rst_n        = 1'b0;
		tests_run    = 0;
		tests_failed = 0;
		errors       = 0;
		pending      = 1'b0;
		fd = $fopen("dv/frontend_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the cases file dv/frontend_cases.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				case (line[0])
					"T": begin
						if (pending) begin
							run_test();
						end
						n = $sscanf(line, "T %s", name);
						start_test(name);
						pending = 1'b1;
					end
					"M": begin
						n = $sscanf(line, "M %h %h", a, d);
						if (n != 2 || a >= 32'(MEM_WORDS * 4)) begin
							$display("Bad memory line in cases file: %s", line);
							errors++;
						end else begin
							mem[a[12:2]] = d;
						end
					end
					"E": begin
						n = $sscanf(line, "E %h %d %d %h", a, rd, wen, d);
						if (n != 4) begin
							$display("Bad retire line in cases file: %s", line);
							errors++;
						end else begin
							expected.push_back('{pc: a, rd: 5'(rd), wen: wen[0], wdata: d});
						end
					end
					default: begin
						$display("Unknown line in cases file: %s", line);
						errors++;
					end
				endcase
			end
			$fclose(fd);
			if (pending) begin
				run_test();
			end
		end
		asserts_failed = uut.u_asserts.violations;
		$display("Summary: %0d tests run, %0d failed, %0d assertion failures, %0d other errors",
			tests_run, tests_failed, asserts_failed, errors);
		if (errors == 0 && tests_failed == 0 && asserts_failed == 0 && tests_run > 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  logic             clock,
	input  logic             rst_n,

	input  logic             if_valid,
	input  logic [31:0]      if_pc,
	input  logic [31:0]      if_inst,
	output logic             if_ready,

	output logic             id_valid,
	output isa_pkg::dec_op_t id_op,
	input  logic             id_ready,

	input  logic             flush
);
	import isa_pkg::*;

	inst_t   inst;
	dec_op_t dec;

	assign inst = if_inst;

	// The register takes a word when it is empty or drains in this cycle.
	assign if_ready = !id_valid || id_ready;

	always_comb begin
		dec           = '0;
		dec.op        = OP_ILLEGAL;
		dec.pc        = if_pc;
		dec.pred_next = if_pc + 32'd4;
		case (inst.i_fmt.opcode)
			OPC_OP_IMM: begin
				if (inst.i_fmt.funct3 == 3'b000) begin
					dec.op  = OP_ADDI;
					dec.rd  = inst.i_fmt.rd;
					dec.rs1 = inst.i_fmt.rs1;
					dec.imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
				end
			end
			OPC_LUI: begin
				dec.op  = OP_LUI;
				dec.rd  = inst.j_fmt.rd;
				dec.imm = {inst.j_fmt.imm20, inst.j_fmt.imm10_1, inst.j_fmt.imm11,
					inst.j_fmt.imm19_12, 12'b0};
			end
			OPC_JAL: begin
				dec.op  = OP_JAL;
				dec.rd  = inst.j_fmt.rd;
				dec.imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
					inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
			end
			OPC_BRANCH: begin
				// Only funct3 000 (BEQ) and 001 (BNE) are supported.
				if (inst.b_fmt.funct3[2:1] == 2'b00) begin
					dec.op  = inst.b_fmt.funct3[0] ? OP_BNE : OP_BEQ;
					dec.rs1 = inst.b_fmt.rs1;
					dec.rs2 = inst.b_fmt.rs2;
					dec.imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
						inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			id_valid <= 1'b0;
		end else if (flush) begin
			id_valid <= 1'b0;
		end else if (if_ready) begin
			id_valid <= if_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (if_valid && if_ready) begin
			id_op <= dec;
		end
	end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  logic             clock,
	input  logic             rst_n,

	input  logic             id_valid,
	input  isa_pkg::dec_op_t id_op,
	output logic             id_ready,

	output logic             retire_valid,
	output isa_pkg::retire_t retire,

	output logic             redirect,
	output logic [31:0]      redirect_pc
);
	import isa_pkg::*;

	logic [31:0] regs [32];
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic [31:0] seq_pc;
	logic [31:0] target;
	logic [31:0] next_pc;
	logic [31:0] result;
	logic        wen;
	logic        taken;
	logic        fire;

	assign id_ready = 1'b1;

	// The op in decode during a redirect is on the wrong path and is dropped.
	assign fire = id_valid && !redirect;

	always_comb begin
		rs1_val = (id_op.rs1 == 5'd0) ? 32'd0 : regs[id_op.rs1];
		rs2_val = (id_op.rs2 == 5'd0) ? 32'd0 : regs[id_op.rs2];
		seq_pc  = id_op.pc + 32'd4;
		target  = id_op.pc + id_op.imm;
		result  = 32'd0;
		wen     = 1'b0;
		taken   = 1'b0;
		case (id_op.op)
			OP_ADDI: begin
				result = rs1_val + id_op.imm;
				wen    = 1'b1;
			end
			OP_LUI: begin
				result = id_op.imm;
				wen    = 1'b1;
			end
			OP_JAL: begin
				result = seq_pc;
				wen    = 1'b1;
				taken  = 1'b1;
			end
			OP_BEQ: taken = (rs1_val == rs2_val);
			OP_BNE: taken = (rs1_val != rs2_val);
			default: ;
		endcase
		next_pc = taken ? target : seq_pc;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			retire_valid <= 1'b0;
			redirect     <= 1'b0;
		end else begin
			retire_valid <= fire;
			redirect     <= fire && (next_pc != id_op.pred_next);
		end
	end

	always_ff @(posedge clock) begin
		if (fire) begin
			retire      <= '{pc: id_op.pc, rd: id_op.rd, wen: wen, wdata: result};
			redirect_pc <= next_pc;
			if (wen && id_op.rd != 5'd0) begin
				regs[id_op.rd] <= result;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter logic [31:0] RESET_PC     = 32'h0000_0000,
	parameter logic [31:0] CACHED_BASE  = 32'h0000_1000,
	parameter logic [31:0] CACHED_LIMIT = 32'h0000_2000
) (
	input  logic                  clock,
	input  logic                  rst_n,

	output logic                  ar_valid,
	output mem_bus_pkg::rd_req_t  ar,
	input  logic                  ar_ready,
	input  logic                  r_valid,
	input  mem_bus_pkg::rd_rsp_t  r,

	output logic                  lookup_valid,
	output logic [31:0]           lookup_addr,
	input  logic                  lookup_done,
	input  logic                  lookup_hit,
	input  logic [31:0]           lookup_data,

	output logic                  fill_valid,
	output logic                  fill_last,
	output logic [31:0]           fill_addr,
	output logic [31:0]           fill_data,

	output logic                  if_valid,
	output logic [31:0]           if_pc,
	output logic [31:0]           if_inst,
	input  logic                  if_ready,

	input  logic                  redirect,
	input  logic [31:0]           redirect_pc
);
	import mem_bus_pkg::*;

	typedef enum logic [2:0] {IDLE, LOOKUP, BUS_ADDR, BUS_DATA, HOLD} state_e;

	state_e      state;
	logic [31:0] pc;
	logic [31:0] inst_q;
	logic [31:0] beat_addr_q;
	rd_req_t     ar_q;
	logic        refill_q;
	logic        kill_q;
	logic        cacheable;
	logic [31:0] line_base;
	logic        start_uncached;
	logic        take_hit;
	logic        take_miss;
	logic        beat;
	logic        critical;

	assign cacheable = (pc >= CACHED_BASE) && (pc < CACHED_LIMIT);
	assign line_base = {pc[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

	assign start_uncached = (state == IDLE) && !redirect && !cacheable;
	assign take_hit       = (state == LOOKUP) && !redirect && lookup_done && lookup_hit;
	assign take_miss      = (state == LOOKUP) && !redirect && lookup_done && !lookup_hit;
	assign beat           = (state == BUS_DATA) && r_valid;
	// During a refill only the beat at the pc's word offset is the fetched word.
	assign critical = !refill_q ||
		(beat_addr_q[LINE_OFFSET_BITS-1:2] == pc[LINE_OFFSET_BITS-1:2]);

	assign lookup_valid = (state == IDLE) && !redirect && cacheable;
	assign lookup_addr  = pc;

	assign ar_valid = (state == BUS_ADDR);
	assign ar       = ar_q;

	assign fill_valid = beat && refill_q;
	assign fill_last  = r.last;
	assign fill_addr  = beat_addr_q;
	assign fill_data  = r.data;

	assign if_valid = (state == HOLD);
	assign if_pc    = pc;
	assign if_inst  = inst_q;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= IDLE;
			pc       <= RESET_PC;
			refill_q <= 1'b0;
			kill_q   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (redirect) begin
						pc <= redirect_pc;
					end else if (cacheable) begin
						state <= LOOKUP;
					end else begin
						refill_q <= 1'b0;
						state    <= BUS_ADDR;
					end
				end
				LOOKUP: begin
					if (redirect) begin
						pc    <= redirect_pc;
						state <= IDLE;
					end else if (take_hit) begin
						state <= HOLD;
					end else if (take_miss) begin
						refill_q <= 1'b1;
						state    <= BUS_ADDR;
					end
				end
				BUS_ADDR, BUS_DATA: begin
					// The bus transaction always runs to its last beat.
					if (redirect) begin
						pc     <= redirect_pc;
						kill_q <= 1'b1;
					end
					if (state == BUS_ADDR && ar_ready) begin
						state <= BUS_DATA;
					end
					if (beat && r.last) begin
						state  <= (kill_q || redirect) ? IDLE : HOLD;
						kill_q <= 1'b0;
					end
				end
				HOLD: begin
					if (redirect) begin
						pc    <= redirect_pc;
						state <= IDLE;
					end else if (if_ready) begin
						pc    <= pc + 32'd4;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start_uncached) begin
			ar_q <= '{addr: pc, len: 4'd0, burst: BURST_FIXED};
		end
		if (take_miss) begin
			ar_q        <= '{addr: line_base, len: 4'(LINE_WORDS - 1), burst: BURST_INCR};
			beat_addr_q <= line_base;
		end
		if (take_hit) begin
			inst_q <= lookup_data;
		end
		if (beat) begin
			beat_addr_q <= beat_addr_q + 32'd4;
			if (critical) begin
				inst_q <= r.data;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
	parameter logic [31:0] RESET_PC     = 32'h0000_0000,
	parameter logic [31:0] CACHED_BASE  = 32'h0000_1000,
	parameter logic [31:0] CACHED_LIMIT = 32'h0000_2000,
	parameter int          CACHE_LINES  = 16
) (
	input  logic                 clock,
	input  logic                 rst_n,

	output logic                 ar_valid,
	output mem_bus_pkg::rd_req_t ar,
	input  logic                 ar_ready,
	input  logic                 r_valid,
	input  mem_bus_pkg::rd_rsp_t r,

	output logic                 retire_valid,
	output isa_pkg::retire_t     retire
);
	import isa_pkg::*;

	logic        lookup_valid;
	logic [31:0] lookup_addr;
	logic        lookup_done;
	logic        lookup_hit;
	logic [31:0] lookup_data;
	logic        fill_valid;
	logic        fill_last;
	logic [31:0] fill_addr;
	logic [31:0] fill_data;
	logic        if_valid;
	logic [31:0] if_pc;
	logic [31:0] if_inst;
	logic        if_ready;
	logic        id_valid;
	dec_op_t     id_op;
	logic        id_ready;
	logic        redirect;
	logic [31:0] redirect_pc;

	fetch_unit #(
		.RESET_PC     (RESET_PC),
		.CACHED_BASE  (CACHED_BASE),
		.CACHED_LIMIT (CACHED_LIMIT)
	) u_fetch (.*);

	icache #(.CACHE_LINES(CACHE_LINES)) u_icache (.*);

	// A redirect from execute flushes the decode register.
	decode_unit u_decode (.flush(redirect), .*);

	execute_unit u_execute (.*);

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
	parameter int CACHE_LINES = 16
) (
	input  logic        clock,
	input  logic        rst_n,

	input  logic        lookup_valid,
	input  logic [31:0] lookup_addr,
	output logic        lookup_done,
	output logic        lookup_hit,
	output logic [31:0] lookup_data,

	input  logic        fill_valid,
	input  logic        fill_last,
	input  logic [31:0] fill_addr,
	input  logic [31:0] fill_data
);
	import mem_bus_pkg::*;

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int WORD_BITS  = LINE_OFFSET_BITS - 2;
	localparam int TAG_BITS   = 32 - INDEX_BITS - LINE_OFFSET_BITS;

	logic [31:0]           data_mem [CACHE_LINES][LINE_WORDS];
	logic [TAG_BITS-1:0]   tag_mem [CACHE_LINES];
	logic [CACHE_LINES-1:0] line_valid;

	logic                  pend_q;
	logic [INDEX_BITS-1:0] idx_q;
	logic [TAG_BITS-1:0]   tag_q;
	logic [WORD_BITS-1:0]  word_q;

	logic [INDEX_BITS-1:0] fill_idx;
	logic [TAG_BITS-1:0]   fill_tag;
	logic [WORD_BITS-1:0]  fill_word;

	assign fill_idx  = fill_addr[LINE_OFFSET_BITS +: INDEX_BITS];
	assign fill_tag  = fill_addr[31 -: TAG_BITS];
	assign fill_word = fill_addr[2 +: WORD_BITS];

	// The compare happens one cycle after the request, on the registered address.
	assign lookup_done = pend_q;
	assign lookup_hit  = line_valid[idx_q] && (tag_mem[idx_q] == tag_q);
	assign lookup_data = data_mem[idx_q][word_q];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			pend_q     <= 1'b0;
			line_valid <= '0;
		end else begin
			pend_q <= lookup_valid;
			if (fill_valid) begin
				// A line being refilled stays invalid until its last beat.
				line_valid[fill_idx] <= fill_last;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			idx_q  <= lookup_addr[LINE_OFFSET_BITS +: INDEX_BITS];
			tag_q  <= lookup_addr[31 -: TAG_BITS];
			word_q <= lookup_addr[2 +: WORD_BITS];
		end
		if (fill_valid) begin
			data_mem[fill_idx][fill_word] <= fill_data;
			if (fill_last) begin
				tag_mem[fill_idx] <= fill_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_JAL    = 7'b1101111,
		OPC_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [2:0] {
		OP_ADDI,
		OP_LUI,
		OP_JAL,
		OP_BEQ,
		OP_BNE,
		OP_ILLEGAL
	} op_e;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic        imm12;
		logic [5:0]  imm10_5;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [3:0]  imm4_1;
		logic        imm11;
		logic [6:0]  opcode;
	} b_fmt_t;

	// The upper 20 bits of this view also give the U-format immediate.
	typedef struct packed {
		logic        imm20;
		logic [9:0]  imm10_1;
		logic        imm11;
		logic [7:0]  imm19_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} j_fmt_t;

	typedef union packed {
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} inst_t;

	typedef struct packed {
		op_e         op;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic [31:0] pred_next;
	} dec_op_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        wen;
		logic [31:0] wdata;
	} retire_t;

endpackage

`default_nettype wire

// File: hdl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	// Burst encodings of the read address channel.
	localparam logic [1:0] BURST_FIXED = 2'b00;
	localparam logic [1:0] BURST_INCR  = 2'b01;

	// One cache line is four 32-bit words.
	localparam int LINE_WORDS       = 4;
	localparam int LINE_OFFSET_BITS = 4;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  len;
		logic [1:0]  burst;
	} rd_req_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
	} rd_rsp_t;

endpackage

`default_nettype wire
